// ==== Makefile ====
# Verilator build and run for the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= mipsTb
FLIST     ?= mipsCore.f
SEED      ?= 0
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All tests passed

VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the testbench seeds its own stimulus; SEED only feeds the Verilator runtime
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== mipsCore.f ====
+incdir+verilog
verilog/mipsPkg.sv
verilog/control.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/dataMemory.sv
verilog/nextPc.sv
verilog/mipsCore.sv
verification/mips_props.sv
verification/mipsChecker.sv
verification/mipsTb.sv

// ==== verification/mipsChecker.sv ====
module mipsChecker import mipsPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        active,
   input  int          row,
   input  logic [31:0] pc,
   input  regWrite_t   rfWrite,
   input  memWrite_t   dmWrite,
   input  logic [31:0] expPc,
   input  regWrite_t   expRf,
   input  memWrite_t   expDm,
   output int          errors,
   output int          checks
);
   int errorCount = 0;
   int checkCount = 0;

   assign errors = errorCount;
   assign checks = checkCount;

   task automatic compareField(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("FAILED row %0d: %s = %h, expected %h", row, name, got, exp);
      end
   endtask

   // sample mid-cycle, well away from the edge that moves the inputs
   always @(negedge clk) begin
      if (reset) begin
         checkCount++;
         if (rfWrite.en !== 1'b0 || dmWrite.en !== 1'b0) begin
            errorCount++;
            $display("FAILED during reset: rfWrite.en = %h, dmWrite.en = %h, expected 0",
                     rfWrite.en, dmWrite.en);
         end
      end else if (active) begin
         compareField("pc", pc, expPc);
         compareField("rfWrite.en", 32'(rfWrite.en), 32'(expRf.en));
         if (expRf.en) begin // addr and data are don't-care without the strobe
            compareField("rfWrite.addr", 32'(rfWrite.addr), 32'(expRf.addr));
            compareField("rfWrite.data", rfWrite.data, expRf.data);
         end
         compareField("dmWrite.en", 32'(dmWrite.en), 32'(expDm.en));
         if (expDm.en) begin
            compareField("dmWrite.addr", 32'(dmWrite.addr), 32'(expDm.addr));
            compareField("dmWrite.data", dmWrite.data, expDm.data);
         end
      end
   end

endmodule

// ==== verification/mipsTb.sv ====
`include "mips_cfg.svh"

module mipsTb import mipsPkg::*; ();
   localparam int PERIOD       = 40;
   localparam int RESET_CYCLES = 16;
   localparam logic [31:0] SEED = 32'h450d3bc7;

   typedef struct packed {
      instrWord_t  instr;
      logic [31:0] pc;
      regWrite_t   rf;
      memWrite_t   dm;
   } row_t;

   logic        clk;
   logic        reset;
   instrWord_t  instr;
   logic [31:0] pc;
   regWrite_t   rfWrite;
   memWrite_t   dmWrite;
   row_t        rows[$];
   row_t        expRow;
   logic        active;
   logic        tableReady;
   int          rowIdx;
   int          errors;
   int          checks;
   logic [31:0] curPc;

   mipsCore DUT (.clk(clk), .reset(reset), .instr(instr), .pc(pc),
                 .rfWrite(rfWrite), .dmWrite(dmWrite));

   mipsChecker uChecker (.clk(clk), .reset(reset), .active(active), .row(rowIdx),
                         .pc(pc), .rfWrite(rfWrite), .dmWrite(dmWrite),
                         .expPc(expRow.pc), .expRf(expRow.rf), .expDm(expRow.dm),
                         .errors(errors), .checks(checks));

   function automatic instrWord_t encodeR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] funct);
      instrWord_t w;
      w.rType = {`SPECIAL, rs, rt, rd, 5'd0, funct};
      return w;
   endfunction

   function automatic instrWord_t encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
      instrWord_t w;
      w.iType = {op, rs, rt, imm};
      return w;
   endfunction

   function automatic instrWord_t encodeJ(logic [5:0] op, logic [25:0] target);
      instrWord_t w;
      w.jType = {op, target};
      return w;
   endfunction

   function automatic regWrite_t regWr(logic [4:0] addr, logic [31:0] data);
      return '{en: 1'b1, addr: addr, data: data};
   endfunction

   function automatic memWrite_t memWr(logic [31:0] byteAddr, logic [31:0] data);
      return '{en: 1'b1, addr: byteAddr[31:2], data: data};
   endfunction

   function automatic logic [31:0] seqPc();
      return curPc + 32'd4;
   endfunction

   // offset counts words relative to the following instruction
   function automatic logic [31:0] branchPc(logic [15:0] off);
      int words;
      words = int'($signed(off));
      return curPc + 32'd4 + 32'(words * 4);
   endfunction

   function automatic logic [31:0] jumpPc(logic [25:0] target);
      logic [31:0] region;
      region = (curPc + 32'd4) & 32'hf000_0000;
      return region | (32'(target) << 2);
   endfunction

   task automatic addRow(input instrWord_t ins, input regWrite_t rf, input memWrite_t dm,
                         input logic [31:0] next);
      row_t r;
      r.instr = ins;
      r.pc    = curPc;
      r.rf    = rf;
      r.dm    = dm;
      rows.push_back(r);
      curPc = next;
   endtask

   task automatic buildProgram();
      logic [31:0] base;
      logic [31:0] link;
      base  = ($urandom % 200) << 2; // word aligned, leaves room for the offsets
      curPc = `RESET_PC;
      addRow(encodeI(`ORI, 0, 8, base[15:0]), regWr(8, base), '0, seqPc());
      addRow(encodeI(`ADDI, 0, 9, 16'h0015), regWr(9, 32'd21), '0, seqPc());
      addRow(encodeI(`ADDI, 0, 10, 16'hfff9), regWr(10, 32'hffff_fff9), '0, seqPc());
      addRow(encodeI(`ADDIU, 0, 11, 16'h8000), regWr(11, 32'hffff_8000), '0, seqPc());
      addRow(encodeI(`ORI, 0, 12, 16'h8000), regWr(12, 32'h0000_8000), '0, seqPc());
      addRow(encodeR(9, 10, 13, `ADD), regWr(13, 32'd14), '0, seqPc());
      addRow(encodeR(9, 10, 14, `SUB), regWr(14, 32'd28), '0, seqPc());
      addRow(encodeR(9, 10, 15, `AND), regWr(15, 32'h11), '0, seqPc());
      addRow(encodeR(9, 12, 16, `OR), regWr(16, 32'h8015), '0, seqPc());
      addRow(encodeR(10, 9, 17, `SLT), regWr(17, 32'd1), '0, seqPc()); // -7 < 21
      addRow(encodeR(9, 10, 18, `SLT), regWr(18, 32'd0), '0, seqPc());
      addRow(encodeI(`SLTIU, 10, 19, 16'h0001), regWr(19, 32'd0), '0, seqPc());
      addRow(encodeI(`SLTIU, 0, 20, 16'h0001), regWr(20, 32'd1), '0, seqPc());
      addRow(encodeI(`SLTIU, 9, 25, 16'hffff), regWr(25, 32'd1), '0, seqPc());
      addRow(encodeI(`SW, 8, 13, 16'h0004), '0, memWr(base + 32'd4, 32'd14), seqPc());
      addRow(encodeI(`SW, 8, 16, 16'h0008), '0, memWr(base + 32'd8, 32'h8015), seqPc());
      addRow(encodeI(`LW, 8, 21, 16'h0004), regWr(21, 32'd14), '0, seqPc());
      addRow(encodeI(`LW, 8, 22, 16'h0008), regWr(22, 32'h8015), '0, seqPc());
      addRow(encodeI(`BEQ, 9, 9, 16'h0002), '0, '0, branchPc(16'h0002));
      addRow(encodeI(`BEQ, 9, 10, 16'h0005), '0, '0, seqPc());
      addRow(encodeI(`BNE, 9, 10, 16'h0001), '0, '0, branchPc(16'h0001));
      addRow(encodeI(`BNE, 13, 21, 16'h0003), '0, '0, seqPc()); // loaded word matches
      addRow(encodeJ(`J, 26'h40), '0, '0, jumpPc(26'h40));
      link = seqPc();
      addRow(encodeJ(`JAL, 26'h80), regWr(31, link), '0, jumpPc(26'h80));
      addRow(encodeR(9, 9, 0, `ADD), regWr(0, 32'd42), '0, seqPc());
      addRow(encodeR(0, 0, 0, `SYSCALL), '0, '0, seqPc());
      addRow(encodeR(9, 9, 5, 6'b111111), '0, '0, seqPc());
      addRow(encodeI(6'b111111, 9, 9, 16'h1234), '0, '0, seqPc());
      addRow(encodeR(0, 0, 23, `OR), regWr(23, 32'd0), '0, seqPc());
      addRow(encodeR(31, 0, 0, `JR), '0, '0, link);
      addRow(encodeI(`ADDI, 31, 24, 16'h0004), regWr(24, link + 32'd4), '0, seqPc());
      addRow(encodeR(0, 0, 0, `SYSCALL), '0, '0, seqPc());
   endtask

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      wait (tableReady);
      #((rows.size() + RESET_CYCLES + 20) * PERIOD);
      $display("watchdog: run did not finish within %0d clock periods",
               rows.size() + RESET_CYCLES + 20);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      reset      = 1'b1;
      instr      = '0; // decodes as an unsupported funct
      active     = 1'b0;
      rowIdx     = 0;
      expRow     = '0;
      tableReady = 1'b0;
      void'($urandom(SEED));
      buildProgram();
      tableReady = 1'b1;
      repeat (RESET_CYCLES - 1) @(posedge clk);
      foreach (rows[i]) begin
         @(posedge clk); // the first pass is the last edge that still sees reset
         reset  <= 1'b0;
         active <= 1'b1;
         rowIdx <= i;
         instr  <= rows[i].instr;
         expRow <= rows[i];
      end
      @(posedge clk);
      active <= 1'b0;
      instr  <= '0;
      @(negedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== verification/mips_props.sv ====
`include "mips_cfg.svh"

module mipsProps import mipsPkg::*; (
   input logic        clk,
   input logic        reset,
   input instrWord_t  instr,
   input logic [31:0] pc,
   input ctrl_t       ctrl,
   input regWrite_t   rfWrite
);
   logic knownOp;

   assign knownOp = instr.rType.opcode inside {`SPECIAL, `ADDI, `ADDIU, `ORI, `SLTIU,
                                               `LW, `SW, `BEQ, `BNE, `J, `JAL};

   pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else $error("pc %h is not word aligned", pc);

   // first cycle out of reset starts at the reset vector
   pcAfterReset: assert property (@(posedge clk) reset |=> pc == `RESET_PC)
      else $error("pc %h after reset, expected the reset vector", pc);

   memExclusive: assert property (@(posedge clk) disable iff (reset)
                                  !(ctrl.memRead && ctrl.memWrite))
      else $error("load and store decoded together");

   noWriteOnBadOp: assert property (@(posedge clk) disable iff (reset)
                                    !knownOp |-> !rfWrite.en)
      else $error("register write for unsupported opcode %h", instr.rType.opcode);

endmodule

bind mipsCore mipsProps uProps (
   .clk     (clk),
   .reset   (reset),
   .instr   (instr),
   .pc      (pc),
   .ctrl    (ctrl),
   .rfWrite (rfWrite)
);

// ==== verilog/alu.sv ====
`include "mips_cfg.svh"

module alu (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic [2:0]  op,
   input  logic        unsignedCmp,
   output logic [31:0] result,
   output logic        zero
);
   logic lessThan;

   // sltiu needs the unsigned view, slt the signed one
   assign lessThan = unsignedCmp ? (a < b) : ($signed(a) < $signed(b));

   always_comb begin
      case (op)
         `ALU_AND: result = a & b;
         `ALU_OR:  result = a | b;
         `ALU_ADD: result = a + b;
         `ALU_SUB: result = a - b;
         `ALU_SLT: result = {31'b0, lessThan};
         default:  result = '0;
      endcase
   end

   assign zero = (result == '0); // branch compare

endmodule

// ==== verilog/control.sv ====
`include "mips_cfg.svh"

module control import mipsPkg::*; (
   input  instrWord_t instr,
   output ctrl_t      ctrl
);
   logic [5:0] opcode;
   logic [5:0] funct;

   assign opcode = instr.rType.opcode;
   assign funct  = instr.rType.funct;

   always_comb begin
      ctrl = '0; // anything not decoded below retires as a no-op
      case (opcode)
         `SPECIAL: begin
            case (funct)
               `ADD: begin
                  ctrl.regDst   = 1'b1;
                  ctrl.aluOp    = `ALU_ADD;
                  ctrl.regWrite = 1'b1;
               end
               `SUB: begin
                  ctrl.regDst   = 1'b1;
                  ctrl.aluOp    = `ALU_SUB;
                  ctrl.regWrite = 1'b1;
               end
               `AND: begin
                  ctrl.regDst   = 1'b1;
                  ctrl.aluOp    = `ALU_AND;
                  ctrl.regWrite = 1'b1;
               end
               `OR: begin
                  ctrl.regDst   = 1'b1;
                  ctrl.aluOp    = `ALU_OR;
                  ctrl.regWrite = 1'b1;
               end
               `SLT: begin
                  ctrl.regDst   = 1'b1;
                  ctrl.aluOp    = `ALU_SLT;
                  ctrl.regWrite = 1'b1;
               end
               `JR:      ctrl.jumpReg = 1'b1;
               `SYSCALL: ; // no side effects in this core
               default:  ;
            endcase
         end
         `ADDI, `ADDIU: begin // no overflow trap, so both behave alike
            ctrl.aluOp    = `ALU_ADD;
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
         end
         `ORI: begin
            ctrl.aluOp    = `ALU_OR;
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.zeroExt  = 1'b1;
         end
         `SLTIU: begin
            ctrl.aluOp       = `ALU_SLT;
            ctrl.regWrite    = 1'b1;
            ctrl.aluSrc      = 1'b1;
            ctrl.unsignedCmp = 1'b1; // immediate still sign-extended
         end
         `LW: begin
            ctrl.memRead  = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluOp    = `ALU_ADD;
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
         end
         `SW: begin
            ctrl.aluOp    = `ALU_ADD;
            ctrl.aluSrc   = 1'b1;
            ctrl.memWrite = 1'b1;
         end
         `BEQ, `BNE: begin
            ctrl.branch   = 1'b1;
            ctrl.branchNe = (opcode == `BNE);
            ctrl.aluOp    = `ALU_SUB; // compare via zero flag
         end
         `J: ctrl.jump = 1'b1;
         `JAL: begin
            ctrl.jump     = 1'b1;
            ctrl.link     = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// ==== verilog/dataMemory.sv ====
`include "mips_cfg.svh"

module dataMemory import mipsPkg::*; (
   input  logic        clk,
   input  memWrite_t   write,
   input  logic [29:0] readAddr,
   output logic [31:0] readData
);
   localparam int AW = $clog2(`DMEM_WORDS);

   logic [31:0]   mem [`DMEM_WORDS];
   logic [AW-1:0] wrIdx;
   logic [AW-1:0] rdIdx;

   // upper word-address bits are ignored, so addresses wrap
   assign wrIdx = write.addr[AW-1:0];
   assign rdIdx = readAddr[AW-1:0];

   always_ff @(posedge clk) begin
      if (write.en) begin
         mem[wrIdx] <= write.data;
      end
   end

   assign readData = mem[rdIdx];

endmodule

// ==== verilog/mipsCore.sv ====
module mipsCore import mipsPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  instrWord_t  instr,
   output logic [31:0] pc,
   output regWrite_t   rfWrite,
   output memWrite_t   dmWrite
);
   ctrl_t       ctrl;
   logic [31:0] rsData;
   logic [31:0] rtData;
   logic [31:0] immExt;
   logic [31:0] aluB;
   logic [31:0] aluResult;
   logic        zero;
   logic [31:0] loadData;
   logic [31:0] pcPlus4;
   logic [31:0] wbData;
   logic [4:0]  wbAddr;

   control uControl (
      .instr (instr),
      .ctrl  (ctrl)
   );

   registerFile uRegFile (
      .clk    (clk),
      .reset  (reset),
      .rsAddr (instr.rType.rs),
      .rtAddr (instr.rType.rt),
      .rsData (rsData),
      .rtData (rtData),
      .write  (rfWrite)
   );

   // ori zero-extends, everything else sign-extends
   assign immExt = ctrl.zeroExt ? {16'b0, instr.iType.imm16}
                                : {{16{instr.iType.imm16[15]}}, instr.iType.imm16};
   assign aluB   = ctrl.aluSrc ? immExt : rtData;

   alu uAlu (
      .a           (rsData),
      .b           (aluB),
      .op          (ctrl.aluOp),
      .unsignedCmp (ctrl.unsignedCmp),
      .result      (aluResult),
      .zero        (zero)
   );

   assign dmWrite = '{en: ctrl.memWrite, addr: aluResult[31:2], data: rtData};

   dataMemory uDataMem (
      .clk      (clk),
      .write    (dmWrite),
      .readAddr (aluResult[31:2]),
      .readData (loadData)
   );

   nextPc uNextPc (
      .clk      (clk),
      .reset    (reset),
      .ctrl     (ctrl),
      .zero     (zero),
      .rsData   (rsData),
      .imm16    (instr.iType.imm16),
      .target26 (instr.jType.target26),
      .pc       (pc),
      .pcPlus4  (pcPlus4)
   );

   always_comb begin
      if (ctrl.link) begin
         wbAddr = 5'd31; // jal return address
         wbData = pcPlus4;
      end else begin
         wbAddr = ctrl.regDst ? instr.rType.rd : instr.rType.rt;
         wbData = ctrl.memToReg ? loadData : aluResult;
      end
   end

   assign rfWrite = '{en: ctrl.regWrite, addr: wbAddr, data: wbData};

endmodule

// ==== verilog/mipsPkg.sv ====
package mipsPkg;

   typedef struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } rType_t;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;
   } iType_t;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [25:0] target26;
   } jType_t;

   // one instruction word, three field layouts
   typedef union packed {
      rType_t rType;
      iType_t iType;
      jType_t jType;
   } instrWord_t;

   typedef struct packed {
      logic       regDst;
      logic       jump;
      logic       jumpReg;
      logic       link;
      logic       branch;
      logic       branchNe;
      logic       memRead;
      logic       memToReg;
      logic [2:0] aluOp;
      logic       regWrite;
      logic       aluSrc;
      logic       zeroExt;
      logic       unsignedCmp;
      logic       memWrite;
   } ctrl_t;

   typedef struct packed {
      logic        en;
      logic [4:0]  addr;
      logic [31:0] data;
   } regWrite_t;

   typedef struct packed {
      logic        en;
      logic [29:0] addr; // word address
      logic [31:0] data;
   } memWrite_t;

endpackage

// ==== verilog/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// primary opcodes, instr[31:26]
`define SPECIAL 6'b000000
`define J       6'b000010
`define JAL     6'b000011
`define BEQ     6'b000100
`define BNE     6'b000101
`define ADDI    6'b001000
`define ADDIU   6'b001001
`define SLTIU   6'b001011
`define ORI     6'b001101
`define LW      6'b100011
`define SW      6'b101011

// funct field of SPECIAL, instr[5:0]
`define ADD     6'b100000
`define SUB     6'b100010
`define AND     6'b100100
`define OR      6'b100101
`define SLT     6'b101010
`define JR      6'b001000
`define SYSCALL 6'b001100

// alu operation select
`define ALU_AND 3'b000
`define ALU_OR  3'b001
`define ALU_ADD 3'b010
`define ALU_SUB 3'b110
`define ALU_SLT 3'b111

`define DMEM_WORDS 256
`define RESET_PC   32'h0000_0000

`endif

// ==== verilog/nextPc.sv ====
`include "mips_cfg.svh"

module nextPc import mipsPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  ctrl_t       ctrl,
   input  logic        zero,
   input  logic [31:0] rsData,
   input  logic [15:0] imm16,
   input  logic [25:0] target26,
   output logic [31:0] pc,
   output logic [31:0] pcPlus4
);
   logic [31:0] branchTarget;
   logic [31:0] jumpTarget;
   logic [31:0] pcNext;
   logic        taken;

   assign pcPlus4 = pc + 32'd4;

   // beq wants zero, bne wants not zero
   assign taken = ctrl.branch && (zero ^ ctrl.branchNe);

   assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
   assign jumpTarget   = {pcPlus4[31:28], target26, 2'b00}; // stays in the 256MB region

   always_comb begin
      if (ctrl.jumpReg) begin
         pcNext = rsData;
      end else if (ctrl.jump) begin
         pcNext = jumpTarget;
      end else if (taken) begin
         pcNext = branchTarget;
      end else begin
         pcNext = pcPlus4;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= `RESET_PC;
      end else begin
         pc <= pcNext;
      end
   end

endmodule

// ==== verilog/registerFile.sv ====
module registerFile import mipsPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic [4:0]  rsAddr,
   input  logic [4:0]  rtAddr,
   output logic [31:0] rsData,
   output logic [31:0] rtData,
   input  regWrite_t   write
);
   logic [31:0] regs [32];
   logic        writeOk;

   // $zero never takes a value, and nothing commits while in reset
   assign writeOk = write.en && (write.addr != 5'd0) && !reset;

   always_ff @(posedge clk) begin
      if (writeOk) begin
         regs[write.addr] <= write.data;
      end
   end

   assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
   assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule
